/* npc_pkg.sv */
package npc_pkg;

    // first fetch address after reset
    localparam logic [31:0] RESET_PC = 32'h8000_0000;

    // unified memory, 4 KiB of words, aliased across the address space
    localparam int MEM_WORDS = 1024;
    localparam int MEM_AW    = 10;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // funct3 values, several share an encoding under different opcodes
    localparam logic [2:0] F3_ADD   = 3'b000;
    localparam logic [2:0] F3_SLTIU = 3'b011;
    localparam logic [2:0] F3_LW    = 3'b010;
    localparam logic [2:0] F3_LBU   = 3'b100;
    localparam logic [2:0] F3_SW    = 3'b010;
    localparam logic [2:0] F3_SB    = 3'b000;
    localparam logic [2:0] F3_BNE   = 3'b001;

    // whole ebreak word, matched exactly
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    // one-hot alu operations
    localparam logic [2:0] ALU_ADD  = 3'b001;
    localparam logic [2:0] ALU_SLTU = 3'b010;
    localparam logic [2:0] ALU_NE   = 3'b100;

    // instruction word seen through each encoding format
    typedef union packed {
        logic [31:0] raw;
        // R format
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        // I format, 12-bit immediate on top
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        // S and B formats, immediate split around rs1/rs2
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        // U and J formats, 20 upper bits
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } inst_word_t;

endpackage

/* inst_decode.sv */
`timescale 1ns/1ps

module inst_decode import npc_pkg::*; (
    input  inst_word_t  inst,
    output logic        reg_wen,
    output logic        mem_ren,
    output logic        mem_wen,
    output logic        mem_byte,
    output logic        src1_is_pc,
    output logic        src2_is_imm,
    output logic        is_jal,
    output logic        is_jalr,
    output logic        is_bne,
    output logic        is_ebreak,
    output logic        wb_from_mem,
    output logic        wb_from_pc4,
    output logic        wb_from_imm,
    output logic [2:0]  alu_op,
    output logic [31:0] imm,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd
);

    // one-hot opcode classes
    logic op_lui;
    logic op_auipc;
    logic op_jal;
    logic op_jalr;
    logic op_branch;
    logic op_load;
    logic op_store;
    logic op_imm;
    logic op_reg;
    logic op_system;
    logic [7:0] f3_d;

    // single instructions
    logic is_add;
    logic is_addi;
    logic is_sltiu;
    logic is_lw;
    logic is_lbu;
    logic is_sw;
    logic is_sb;

    // immediate format classes
    logic fmt_i;
    logic fmt_s;
    logic fmt_b;
    logic fmt_u;
    logic fmt_j;
    logic use_add;

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign op_lui    = (inst.r.opcode == OP_LUI);
    assign op_auipc  = (inst.r.opcode == OP_AUIPC);
    assign op_jal    = (inst.r.opcode == OP_JAL);
    assign op_jalr   = (inst.r.opcode == OP_JALR);
    assign op_branch = (inst.r.opcode == OP_BRANCH);
    assign op_load   = (inst.r.opcode == OP_LOAD);
    assign op_store  = (inst.r.opcode == OP_STORE);
    assign op_imm    = (inst.r.opcode == OP_IMM);
    assign op_reg    = (inst.r.opcode == OP_REG);
    assign op_system = (inst.r.opcode == OP_SYSTEM);

    // funct3 as one-hot, indexed by the F3_* codes
    assign f3_d = 8'b1 << inst.r.funct3;

    // add needs funct7 zero, otherwise it is sub
    assign is_add    = op_reg & f3_d[F3_ADD] & (inst.r.funct7 == 7'd0);
    assign is_addi   = op_imm & f3_d[F3_ADD];
    assign is_sltiu  = op_imm & f3_d[F3_SLTIU];
    assign is_lw     = op_load & f3_d[F3_LW];
    assign is_lbu    = op_load & f3_d[F3_LBU];
    assign is_sw     = op_store & f3_d[F3_SW];
    assign is_sb     = op_store & f3_d[F3_SB];
    assign is_jal    = op_jal;
    assign is_jalr   = op_jalr & f3_d[F3_ADD];
    assign is_bne    = op_branch & f3_d[F3_BNE];
    assign is_ebreak = op_system & (inst.raw == EBREAK_WORD);

    // control strobes, unknown encodings leave all of them low
    assign reg_wen     = op_lui | op_auipc | is_jal | is_jalr | is_add | is_addi
                       | is_sltiu | is_lw | is_lbu;
    assign mem_ren     = is_lw | is_lbu;
    assign mem_wen     = is_sw | is_sb;
    assign mem_byte    = is_lbu | is_sb;
    assign wb_from_mem = is_lw | is_lbu;
    assign wb_from_pc4 = is_jal | is_jalr;
    assign wb_from_imm = op_lui;

    // operand selects
    assign src1_is_pc  = op_auipc;
    assign src2_is_imm = op_auipc | is_addi | is_sltiu | is_jalr | mem_ren | mem_wen;

    // adder also forms load/store addresses and the jalr target
    assign use_add = is_add | is_addi | op_auipc | is_jalr | mem_ren | mem_wen;
    assign alu_op  = ({3{use_add}} & ALU_ADD)
                   | ({3{is_sltiu}} & ALU_SLTU)
                   | ({3{is_bne}} & ALU_NE);

    assign rs1 = inst.r.rs1;
    assign rs2 = inst.r.rs2;
    assign rd  = inst.r.rd;

    // immediates, all sign extended except U
    assign imm_i = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
    assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_b = {{19{inst.s.imm_hi[6]}}, inst.s.imm_hi[6], inst.s.imm_lo[0],
                    inst.s.imm_hi[5:0], inst.s.imm_lo[4:1], 1'b0};
    assign imm_u = {inst.u.imm_31_12, 12'd0};
    // J bits sit scrambled in the upper 20
    assign imm_j = {{11{inst.u.imm_31_12[19]}}, inst.u.imm_31_12[19],
                    inst.u.imm_31_12[7:0], inst.u.imm_31_12[8],
                    inst.u.imm_31_12[18:9], 1'b0};

    assign fmt_i = is_addi | is_sltiu | is_jalr | is_lw | is_lbu;
    assign fmt_s = is_sw | is_sb;
    assign fmt_b = is_bne;
    assign fmt_u = op_lui | op_auipc;
    assign fmt_j = is_jal;

    // and-or select by class
    assign imm = ({32{fmt_i}} & imm_i)
               | ({32{fmt_s}} & imm_s)
               | ({32{fmt_b}} & imm_b)
               | ({32{fmt_u}} & imm_u)
               | ({32{fmt_j}} & imm_j);

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    // x0 entry exists but is never read
    logic [31:0] regs [32];
    logic        wr_ok;

    // writes to x0 are dropped
    assign wr_ok = wen & (waddr != 5'd0);

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, x0 forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu import npc_pkg::*; (
    input  logic [31:0] src1,
    input  logic [31:0] src2,
    input  logic [2:0]  alu_op,
    output logic [31:0] alu_result
);

    logic [31:0] sum;
    logic        less_u;
    logic        differ;
    logic        sel_add;
    logic        sel_sltu;
    logic        sel_ne;

    assign sum    = src1 + src2;
    // unsigned compare for sltiu
    assign less_u = (src1 < src2);
    // inequality for bne
    assign differ = (src1 != src2);

    assign sel_add  = |(alu_op & ALU_ADD);
    assign sel_sltu = |(alu_op & ALU_SLTU);
    assign sel_ne   = |(alu_op & ALU_NE);

    // one-hot and-or, zero when no op selected
    assign alu_result = ({32{sel_add}} & sum)
                      | ({32{sel_sltu}} & {31'd0, less_u})
                      | ({32{sel_ne}} & {31'd0, differ});

endmodule

/* npc.sv */
`timescale 1ns/1ps

module npc import npc_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] fetch_addr,
    input  logic [31:0] fetch_data,
    output logic [31:0] data_addr,
    output logic [31:0] mem_wdata,
    output logic        mem_wen,
    output logic        data_byte,
    output logic [3:0]  mem_wmask,
    input  logic [31:0] rdata,
    output logic [31:0] pc,
    output logic        wb_en,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data,
    output logic        halt
);

    inst_word_t  inst;
    logic        reg_wen;
    logic        mem_ren;
    logic        dec_mem_wen;
    logic        mem_byte;
    logic        src1_is_pc;
    logic        src2_is_imm;
    logic        is_jal;
    logic        is_jalr;
    logic        is_bne;
    logic        is_ebreak;
    logic        wb_from_mem;
    logic        wb_from_pc4;
    logic        wb_from_imm;
    logic [2:0]  alu_op;
    logic [31:0] imm;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] alu_result;
    logic [31:0] pc_plus4;
    logic        bne_taken;
    logic [31:0] next_pc;

    // fetch straight from pc
    assign fetch_addr = pc;
    assign inst       = inst_word_t'(fetch_data);

    inst_decode u_inst_decode (
        .inst        (inst),
        .reg_wen     (reg_wen),
        .mem_ren     (mem_ren),
        .mem_wen     (dec_mem_wen),
        .mem_byte    (mem_byte),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .is_jal      (is_jal),
        .is_jalr     (is_jalr),
        .is_bne      (is_bne),
        .is_ebreak   (is_ebreak),
        .wb_from_mem (wb_from_mem),
        .wb_from_pc4 (wb_from_pc4),
        .wb_from_imm (wb_from_imm),
        .alu_op      (alu_op),
        .imm         (imm),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .wen    (wb_en),
        .waddr  (rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (wb_data),
        .rdata1 (src1),
        .rdata2 (src2)
    );

    assign alu_src1 = src1_is_pc ? pc : src1;
    assign alu_src2 = src2_is_imm ? imm : src2;

    alu u_alu (
        .src1       (alu_src1),
        .src2       (alu_src2),
        .alu_op     (alu_op),
        .alu_result (alu_result)
    );

    // next pc, jalr target comes from the adder
    assign pc_plus4  = pc + 32'd4;
    assign bne_taken = is_bne & (|alu_result);
    assign next_pc   = is_jalr ? (alu_result & ~32'd1) :
                       (is_jal | bne_taken) ? (pc + imm) :
                       pc_plus4;

    // pc holds on ebreak and for good once halted
    always_ff @(posedge clk) begin
        if (reset) begin
            pc   <= RESET_PC;
            halt <= 1'b0;
        end else begin
            if (is_ebreak) begin
                halt <= 1'b1;
            end
            if (!halt && !is_ebreak) begin
                pc <= next_pc;
            end
        end
    end

    // write-back priority mem, pc+4, imm, alu
    assign wb_data = wb_from_mem ? rdata :
                     wb_from_pc4 ? pc_plus4 :
                     wb_from_imm ? imm :
                     alu_result;
    assign wb_en   = reg_wen & ~halt;
    assign wb_rd   = rd;

    // data side, address from rs1 + imm
    assign data_addr = alu_result;
    assign data_byte = mem_byte & mem_ren;
    assign mem_wen   = dec_mem_wen & ~halt;
    // sb byte copied to every lane, mask picks one
    assign mem_wdata = mem_byte ? {4{src2[7:0]}} : src2;
    assign mem_wmask = mem_byte ? (4'b0001 << alu_result[1:0]) : 4'b1111;

endmodule

/* unified_mem.sv */
`timescale 1ns/1ps

module unified_mem import npc_pkg::*; (
    input  logic        clk,
    input  logic [31:0] fetch_addr,
    input  logic [31:0] data_addr,
    input  logic [31:0] wdata,
    input  logic [31:0] load_data,
    input  logic        wen,
    input  logic        load_en,
    input  logic        data_byte,
    input  logic [3:0]  wmask,
    output logic [31:0] fetch_data,
    output logic [31:0] rdata,
    input  logic [31:0] load_addr
);

    logic [31:0]       mem [MEM_WORDS];
    logic [MEM_AW-1:0] fetch_idx;
    logic [MEM_AW-1:0] data_idx;
    logic [MEM_AW-1:0] load_idx;
    logic [31:0]       data_word;
    logic [7:0]        data_lane;

    // word index only, upper bits alias
    assign fetch_idx = fetch_addr[MEM_AW+1:2];
    assign data_idx  = data_addr[MEM_AW+1:2];
    assign load_idx  = load_addr[MEM_AW+1:2];

    assign fetch_data = mem[fetch_idx];
    assign data_word  = mem[data_idx];

    // lbu picks the lane by the low address bits
    assign data_lane = data_word[8*data_addr[1:0] +: 8];
    assign rdata     = data_byte ? {24'd0, data_lane} : data_word;

    // preload wins over a core store in the same cycle
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end else if (wen) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    mem[data_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* npc_soc.sv */
`timescale 1ns/1ps

module npc_soc (
    input  logic        clk,
    input  logic        reset,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    output logic [31:0] pc,
    output logic [31:0] wb_data,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic        wb_en,
    output logic        mem_wen,
    output logic        halt,
    output logic [4:0]  wb_rd,
    output logic [3:0]  mem_wmask
);

    logic [31:0] fetch_addr;
    logic [31:0] fetch_data;
    logic [31:0] rdata;
    logic        data_byte;
    logic        mem_load_en;

    // preload only while the core sits in reset
    assign mem_load_en = load_en & reset;

    npc u_npc (
        .clk        (clk),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .data_addr  (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_wen    (mem_wen),
        .data_byte  (data_byte),
        .mem_wmask  (mem_wmask),
        .rdata      (rdata),
        .pc         (pc),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .halt       (halt)
    );

    unified_mem u_unified_mem (
        .clk        (clk),
        .fetch_addr (fetch_addr),
        .data_addr  (mem_addr),
        .wdata      (mem_wdata),
        .load_data  (load_data),
        .wen        (mem_wen),
        .load_en    (mem_load_en),
        .data_byte  (data_byte),
        .wmask      (mem_wmask),
        .fetch_data (fetch_data),
        .rdata      (rdata),
        .load_addr  (load_addr)
    );

endmodule

/* npc_soc_chk.sv */
`timescale 1ns/1ps

module npc_soc_chk import npc_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic [31:0] pc,
    input logic        halt,
    input logic        wb_en,
    input logic        mem_wen,
    input logic [3:0]  mem_wmask
);

    // failed properties so far
    int fail_count = 0;

    // first cycle out of reset
    reset_state: assert property (@(posedge clk)
        $past(reset) && !reset |-> !halt && pc == RESET_PC)
        else begin
            $error("halt set or pc off the reset value in the first cycle after reset");
            fail_count++;
        end

    // halt is sticky and freezes the pc
    halt_sticky: assert property (@(posedge clk) disable iff (reset)
        halt |=> halt && $stable(pc))
        else begin
            $error("halt dropped or pc moved while halted");
            fail_count++;
        end

    halt_no_write: assert property (@(posedge clk) disable iff (reset)
        halt |-> !wb_en && !mem_wen)
        else begin
            $error("write strobe high while halted");
            fail_count++;
        end

    // full mask for sw or a single lane for sb
    store_mask: assert property (@(posedge clk) disable iff (reset)
        mem_wen |-> (mem_wmask == 4'b1111) || $onehot(mem_wmask))
        else begin
            $error("store mask neither full nor a single lane");
            fail_count++;
        end

endmodule

bind npc_soc npc_soc_chk u_npc_soc_chk (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .halt      (halt),
    .wb_en     (wb_en),
    .mem_wen   (mem_wen),
    .mem_wmask (mem_wmask)
);

/* tb_npc_soc.sv */
`timescale 1ns/1ps

module tb_npc_soc import npc_pkg::*; ();

    // instruction kinds of the program builder and model
    localparam int K_LUI    = 0;
    localparam int K_AUIPC  = 1;
    localparam int K_JAL    = 2;
    localparam int K_JALR   = 3;
    localparam int K_ADD    = 4;
    localparam int K_ADDI   = 5;
    localparam int K_SLTIU  = 6;
    localparam int K_LW     = 7;
    localparam int K_LBU    = 8;
    localparam int K_SW     = 9;
    localparam int K_SB     = 10;
    localparam int K_BNE    = 11;
    localparam int K_EBREAK = 12;

    localparam int BODY_LEN       = 200;
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        reset;
    logic        load_en;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic [31:0] pc;
    logic [31:0] wb_data;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        wb_en;
    logic        mem_wen;
    logic        halt;
    logic [4:0]  wb_rd;
    logic [3:0]  mem_wmask;

    integer      seed;
    int          n;
    int          cycles;
    int          value_errs;
    int          other_errs;

    // model state
    logic [31:0] m_mem [MEM_WORDS];
    logic [31:0] m_reg [32];
    logic [31:0] trace_reg [32];
    logic [31:0] m_pc;
    logic        m_halt;

    // program slots as built, indexed by word
    int          p_kind [MEM_WORDS];
    logic [4:0]  p_rd [MEM_WORDS];
    logic [4:0]  p_rs1 [MEM_WORDS];
    logic [4:0]  p_rs2 [MEM_WORDS];
    logic [31:0] p_imm [MEM_WORDS];
    logic        is_target [MEM_WORDS];

    npc_soc u_npc_soc (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .pc        (pc),
        .wb_data   (wb_data),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .wb_en     (wb_en),
        .mem_wen   (mem_wen),
        .halt      (halt),
        .wb_rd     (wb_rd),
        .mem_wmask (mem_wmask)
    );

    always #50 clk = ~clk;

    function automatic int rand_below(input int lim);
        return $unsigned($random(seed)) % lim;
    endfunction

    // background words, every address bit matters
    function automatic logic [31:0] fill_word(input int idx);
        return (32'h9e37_79b9 * 32'(idx + 1)) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] lane_bits(input logic [3:0] wm);
        return {{8{wm[3]}}, {8{wm[2]}}, {8{wm[1]}}, {8{wm[0]}}};
    endfunction

    // rv32i encodings by format
    function automatic logic [31:0] encode(input int k, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [31:0] im);
        logic [31:0] w;
        case (k)
            K_LUI:   w = {im[31:12], rd, OP_LUI};
            K_AUIPC: w = {im[31:12], rd, OP_AUIPC};
            K_JAL:   w = {im[20], im[10:1], im[11], im[19:12], rd, OP_JAL};
            K_JALR:  w = {im[11:0], rs1, 3'b000, rd, OP_JALR};
            K_ADD:   w = {7'd0, rs2, rs1, F3_ADD, rd, OP_REG};
            K_ADDI:  w = {im[11:0], rs1, F3_ADD, rd, OP_IMM};
            K_SLTIU: w = {im[11:0], rs1, F3_SLTIU, rd, OP_IMM};
            K_LW:    w = {im[11:0], rs1, F3_LW, rd, OP_LOAD};
            K_LBU:   w = {im[11:0], rs1, F3_LBU, rd, OP_LOAD};
            K_SW:    w = {im[11:5], rs2, rs1, F3_SW, im[4:0], OP_STORE};
            K_SB:    w = {im[11:5], rs2, rs1, F3_SB, im[4:0], OP_STORE};
            K_BNE:   w = {im[12], im[10:5], rs2, rs1, F3_BNE, im[4:1], im[11], OP_BRANCH};
            default: w = EBREAK_WORD;
        endcase
        return w;
    endfunction

    task automatic emit_inst(input int k, input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [31:0] im);
        p_kind[10'(n)] = k;
        p_rd[10'(n)]   = rd;
        p_rs1[10'(n)]  = rs1;
        p_rs2[10'(n)]  = rs2;
        p_imm[10'(n)]  = im;
        m_mem[10'(n)]  = encode(k, rd, rs1, rs2, im);
        n++;
    endtask

    task automatic build_program();
        int          pick;
        int          k;
        int          body_end;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] r;
        logic [31:0] sext;
        for (int i = 0; i < MEM_WORDS; i++) begin
            m_mem[10'(i)]     = fill_word(i);
            is_target[10'(i)] = 1'b0;
            p_kind[10'(i)]    = K_EBREAK;
        end
        n = 0;
        // x31 is the data base, x30 the jalr anchor
        emit_inst(K_LUI, 5'd31, 5'd0, 5'd0, RESET_PC);
        for (int i = 1; i < 31; i++) begin
            r = $random(seed);
            emit_inst(K_ADDI, 5'(i), 5'd0, 5'd0, {{20{r[11]}}, r[11:0]});
        end
        body_end = n + BODY_LEN;
        while (n < body_end) begin
            pick = rand_below(13);
            rd   = 5'(rand_below(30));
            rs1  = 5'(rand_below(32));
            rs2  = 5'(rand_below(32));
            r    = $random(seed);
            sext = {{20{r[11]}}, r[11:0]};
            // forward skip of 1 to 3 words
            k    = 1 + rand_below(3);
            case (pick)
                0: emit_inst(K_LUI, rd, 5'd0, 5'd0, {r[31:12], 12'd0});
                1: emit_inst(K_AUIPC, rd, 5'd0, 5'd0, {r[31:12], 12'd0});
                2: begin
                    is_target[10'(n + k)] = 1'b1;
                    emit_inst(K_JAL, rd, 5'd0, 5'd0, 32'(4 * k));
                end
                3: begin
                    // pair only where no branch can land on the jalr
                    if (n + 1 < body_end && !is_target[10'(n + 1)]) begin
                        emit_inst(K_AUIPC, 5'd30, 5'd0, 5'd0, 32'd0);
                        is_target[10'(n + k)] = 1'b1;
                        // odd offset now and then, bit 0 gets cleared
                        emit_inst(K_JALR, rd, 5'd30, 5'd0, 32'(4 + 4 * k) | {31'd0, r[0]});
                    end else begin
                        emit_inst(K_ADD, rd, rs1, rs2, 32'd0);
                    end
                end
                4: emit_inst(K_ADD, rd, rs1, rs2, 32'd0);
                5, 6: emit_inst(K_ADDI, rd, rs1, 5'd0, sext);
                7: emit_inst(K_SLTIU, rd, rs1, 5'd0, sext);
                8: emit_inst(K_LW, rd, 5'd31, 5'd0, 32'(1024 + 4 * rand_below(64)));
                9: emit_inst(K_LBU, rd, 5'd31, 5'd0,
                             32'(1024 + 4 * rand_below(64) + rand_below(4)));
                10: emit_inst(K_SW, 5'd0, 5'd31, rs2, 32'(1024 + 4 * rand_below(64)));
                11: emit_inst(K_SB, 5'd0, 5'd31, rs2,
                              32'(1024 + 4 * rand_below(64) + rand_below(4)));
                default: begin
                    // equal operands about a quarter of the time
                    if (r[1:0] == 2'd0) begin
                        rs2 = rs1;
                    end
                    is_target[10'(n + k)] = 1'b1;
                    emit_inst(K_BNE, 5'd0, rs1, rs2, 32'(4 * k));
                end
            endcase
        end
        // tail covers jumps past the last body word
        for (int i = 0; i < 4; i++) begin
            emit_inst(K_EBREAK, 5'd0, 5'd0, 5'd0, 32'd0);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("error: %s is %h, expected %h (pc %h)", name, got, exp, m_pc);
        value_errs++;
    endtask

    task automatic report_failure(input string what);
        $display("failure: %s", what);
        other_errs++;
    endtask

    // compare one trace record with the model, then step the model
    task automatic check_cycle();
        logic [9:0]  slot;
        int          k;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] im;
        logic [31:0] wd;
        logic [31:0] nxt;
        logic [31:0] ma;
        logic [31:0] ewd;
        logic [31:0] bitm;
        logic [3:0]  wm;
        logic        we;
        logic        me;
        logic        is_load;
        slot    = m_pc[11:2];
        k       = p_kind[slot];
        rd      = p_rd[slot];
        a       = m_reg[p_rs1[slot]];
        b       = m_reg[p_rs2[slot]];
        im      = p_imm[slot];
        we      = 1'b1;
        me      = 1'b0;
        is_load = 1'b0;
        wd      = 32'd0;
        ma      = 32'd0;
        ewd     = 32'd0;
        wm      = 4'd0;
        nxt     = m_pc + 32'd4;
        case (k)
            K_LUI:   wd = im;
            K_AUIPC: wd = m_pc + im;
            K_JAL: begin
                wd  = m_pc + 32'd4;
                nxt = m_pc + im;
            end
            K_JALR: begin
                wd  = m_pc + 32'd4;
                nxt = (a + im) & ~32'd1;
            end
            K_ADD:   wd = a + b;
            K_ADDI:  wd = a + im;
            K_SLTIU: wd = (a < im) ? 32'd1 : 32'd0;
            K_LW: begin
                is_load = 1'b1;
                ma      = a + im;
                wd      = m_mem[ma[11:2]];
            end
            K_LBU: begin
                is_load = 1'b1;
                ma      = a + im;
                wd      = (m_mem[ma[11:2]] >> (8 * ma[1:0])) & 32'hff;
            end
            K_SW: begin
                we  = 1'b0;
                me  = 1'b1;
                ma  = a + im;
                wm  = 4'b1111;
                ewd = b;
            end
            K_SB: begin
                we  = 1'b0;
                me  = 1'b1;
                ma  = a + im;
                wm  = 4'b0001 << ma[1:0];
                ewd = {24'd0, b[7:0]} << (8 * ma[1:0]);
            end
            K_BNE: begin
                we = 1'b0;
                if (a != b) begin
                    nxt = m_pc + im;
                end
            end
            default: begin
                // ebreak, pc stays put
                we     = 1'b0;
                nxt    = m_pc;
                m_halt = 1'b1;
            end
        endcase
        bitm = lane_bits(wm);

        assert (pc === m_pc) else report_mismatch("pc", pc, m_pc);
        assert (halt === 1'b0) else report_mismatch("halt", 32'(halt), 32'd0);
        assert (wb_en === we) else report_mismatch("wb_en", 32'(wb_en), 32'(we));
        if (we) begin
            assert (wb_rd === rd) else report_mismatch("wb_rd", 32'(wb_rd), 32'(rd));
            assert (wb_data === wd) else report_mismatch("wb_data", wb_data, wd);
        end
        assert (mem_wen === me) else report_mismatch("mem_wen", 32'(mem_wen), 32'(me));
        if (me || is_load) begin
            assert (mem_addr === ma) else report_mismatch("mem_addr", mem_addr, ma);
        end
        if (me) begin
            assert (mem_wmask === wm) else report_mismatch("mem_wmask", 32'(mem_wmask), 32'(wm));
            // only the enabled lanes carry data
            assert ((mem_wdata & bitm) === ewd)
                else report_mismatch("mem_wdata", mem_wdata & bitm, ewd);
        end

        // register state as seen through the trace
        if (wb_en === 1'b1 && wb_rd != 5'd0) begin
            trace_reg[wb_rd] = wb_data;
        end
        if (we && rd != 5'd0) begin
            m_reg[rd] = wd;
        end
        if (me) begin
            m_mem[ma[11:2]] = (m_mem[ma[11:2]] & ~bitm) | (ewd & bitm);
        end
        m_pc = nxt;
    endtask

    initial begin
        seed       = 32'h856d;
        clk        = 1'b0;
        reset      = 1'b1;
        load_en    = 1'b0;
        load_addr  = 32'd0;
        load_data  = 32'd0;
        value_errs = 0;
        other_errs = 0;
        m_halt     = 1'b0;
        m_pc       = RESET_PC;
        for (int r = 0; r < 32; r++) begin
            m_reg[5'(r)]     = 32'd0;
            trace_reg[5'(r)] = 32'd0;
        end
        build_program();

        // whole memory through the load port, core held in reset
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = RESET_PC + 32'(4 * i);
            load_data = m_mem[10'(i)];
        end
        @(negedge clk);
        load_en = 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
        end
        reset = 1'b0;

        // first record shows the instruction at the reset pc
        cycles = 0;
        while (!m_halt && cycles < TIMEOUT_CYCLES) begin
            check_cycle();
            cycles++;
            @(negedge clk);
        end

        if (!m_halt) begin
            report_failure("no ebreak reached within 2000 cycles, run timed out");
        end else begin
            // halted, pc frozen and no writes
            for (int i = 0; i < 4; i++) begin
                assert (halt === 1'b1) else report_mismatch("halt", 32'(halt), 32'd1);
                assert (pc === m_pc) else report_mismatch("pc", pc, m_pc);
                assert (wb_en === 1'b0 && mem_wen === 1'b0)
                    else report_failure("register or memory write while halted");
                @(negedge clk);
            end
            for (int r = 1; r < 32; r++) begin
                assert (trace_reg[5'(r)] === m_reg[5'(r)])
                    else report_mismatch($sformatf("x%0d", r), trace_reg[5'(r)], m_reg[5'(r)]);
            end
        end
        other_errs += u_npc_soc.u_npc_soc_chk.fail_count;

        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
npc_pkg.sv
inst_decode.sv
reg_file.sv
alu.sv
npc.sv
unified_mem.sv
npc_soc.sv
npc_soc_chk.sv
tb_npc_soc.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the run from its log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_npc_soc -f sources.f -o sim_npc_soc \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_npc_soc +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
